/* sources.f */
+incdir+common
common/rv_pkg.sv
common/rv_dec_if.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core_top.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb \
  -Mdir obj_dir -o rv_core_sim -f sources.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

/* tests/rv_core_tb.sv */
// testbench: program rom, wishbone memory, reference model, trace comparator, timeout
`default_nettype none
`include "rv_cfg.svh"

module rv_core_tb;

  // 40 instructions at worst 5 cycles each, plus slack
  localparam int TIMEOUT_CYCLES = 40 * 5 + 100;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic                clk;
  logic                rst_n;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [31:0]         imem_data;
  logic [`RV_XLEN-1:0] wb_adr;
  logic [`RV_XLEN-1:0] wb_wdata;
  logic                wb_we;
  logic                wb_cyc;
  logic                wb_stb;
  logic [`RV_XLEN-1:0] wb_rdata = '0;
  logic                wb_ack = 1'b0;
  logic                halt;
  logic                illegal;
  logic                retire_valid;
  logic [`RV_XLEN-1:0] retire_pc;
  logic [4:0]          retire_rd;
  logic [`RV_XLEN-1:0] retire_wdata;
  logic                retire_wen;

  logic [31:0]         rom [64];
  logic [`RV_XLEN-1:0] mem [64];
  logic [`RV_XLEN-1:0] init_mem [64];
  // reference machine state
  logic [`RV_XLEN-1:0] ref_mem [64];
  logic [`RV_XLEN-1:0] ref_rf [32];
  logic [`RV_XLEN-1:0] ref_pc;
  logic                ref_halted;
  // expected trace of the last modeled instruction
  logic [`RV_XLEN-1:0] exp_pc;
  logic [4:0]          exp_rd;
  logic                exp_wen;
  logic [`RV_XLEN-1:0] exp_wdata;
  int                  wait_cnt;
  int                  checks = 0;
  int                  cmp_errors = 0;
  int                  end_errors = 0;
  int unsigned         seed_ret;

  rv_core_top UUT (.*);

  bind rv_core_top rv_core_props u_props (
    .clk (clk), .rst_n (rst_n), .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_ack (wb_ack),
    .wb_we (wb_we), .wb_adr (wb_adr), .wb_wdata (wb_wdata), .halt (halt),
    .retire_valid (retire_valid), .retire_wen (retire_wen), .retire_rd (retire_rd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // rom answers in the same cycle
  assign imem_data = rom[imem_addr[7:2]];

  // instruction encoders
  function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input int op, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input int op, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // one instruction of the reference machine, ISA rules only
  function automatic void ref_step();
    logic [31:0]         instr;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] i_imm;
    logic [`RV_XLEN-1:0] s_imm;
    logic [`RV_XLEN-1:0] b_imm;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] j_imm;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] npc;
    logic [`RV_XLEN-1:0] wd;
    logic                wr;
    logic                take;
    instr = rom[ref_pc[7:2]];
    rd    = instr[11:7];
    a     = ref_rf[instr[19:15]];
    b     = ref_rf[instr[24:20]];
    i_imm = {{52{instr[31]}}, instr[31:20]};
    s_imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    b_imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    u_imm = {{32{instr[31]}}, instr[31:12], 12'h000};
    j_imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    exp_pc = ref_pc;
    npc    = ref_pc + 4;
    wr     = 1'b1;
    wd     = '0;
    take   = 1'b0;
    case (instr[6:0])
      7'h37: wd = u_imm;
      7'h17: wd = ref_pc + u_imm;
      7'h6f: begin
        wd  = ref_pc + 4;
        npc = ref_pc + j_imm;
      end
      7'h67: begin
        // target loses bit 0
        wd  = ref_pc + 4;
        npc = (a + i_imm) & ~64'd1;
      end
      7'h63: begin
        wr = 1'b0;
        case (instr[14:12])
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = ($signed(a) < $signed(b));
          3'd5:    take = ($signed(a) >= $signed(b));
          default: take = 1'b0;
        endcase
        if (take) begin
          npc = ref_pc + b_imm;
        end
      end
      7'h03: begin
        addr = a + i_imm;
        wd   = ref_mem[addr[8:3]];
      end
      7'h23: begin
        wr   = 1'b0;
        addr = a + s_imm;
        ref_mem[addr[8:3]] = b;
      end
      7'h13: begin
        case (instr[14:12])
          3'd0:    wd = a + i_imm;
          3'd2:    wd = ($signed(a) < $signed(i_imm)) ? 64'd1 : 64'd0;
          3'd4:    wd = a ^ i_imm;
          3'd6:    wd = a | i_imm;
          default: wd = a & i_imm;
        endcase
      end
      7'h33: begin
        case ({instr[31:25], instr[14:12]})
          10'h100: wd = a - b;
          10'h007: wd = a & b;
          10'h006: wd = a | b;
          10'h004: wd = a ^ b;
          10'h002: wd = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          10'h003: wd = (a < b) ? 64'd1 : 64'd0;
          10'h001: wd = a << b[5:0];
          10'h005: wd = a >> b[5:0];
          default: wd = a + b;
        endcase
      end
      default: begin
        // ebreak or anything unknown stops the machine
        wr          = 1'b0;
        ref_halted  = 1'b1;
      end
    endcase
    exp_rd    = rd;
    exp_wen   = wr && (rd != '0);
    exp_wdata = wd;
    if (exp_wen) begin
      ref_rf[rd] = wd;
    end
    if (!ref_halted) begin
      ref_pc = npc;
    end
  endfunction

  // wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= init_mem[i];
      end
      wb_ack   <= 1'b0;
      wait_cnt <= $urandom_range(3, 0);
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;
      wait_cnt <= $urandom_range(3, 0);
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt == 0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[wb_adr[8:3]] <= wb_wdata;
        end else begin
          wb_rdata <= mem[wb_adr[8:3]];
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  // trace comparator
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        ref_mem[i] = init_mem[i];
      end
      for (int i = 0; i < 32; i++) begin
        ref_rf[i] = '0;
      end
      ref_pc      = `RV_PC_RESET;
      ref_halted  = 1'b0;
    end else if (retire_valid) begin
      assert (!ref_halted) else begin
        cmp_errors++;
        $display("core retired an instruction at pc %h after it should have stopped",
                 retire_pc);
      end
      if (!ref_halted) begin
        ref_step();
        checks++;
        assert (retire_pc == exp_pc) else begin
          cmp_errors++;
          $display("ERROR retire_pc got %h expected %h", retire_pc, exp_pc);
        end
        assert (retire_wen == exp_wen) else begin
          cmp_errors++;
          $display("ERROR retire_wen at pc %h got %h expected %h", exp_pc, retire_wen,
                   exp_wen);
        end
        if (exp_wen) begin
          assert (retire_rd == exp_rd) else begin
            cmp_errors++;
            $display("ERROR retire_rd at pc %h got %h expected %h", exp_pc, retire_rd,
                     exp_rd);
          end
          assert (retire_wdata == exp_wdata) else begin
            cmp_errors++;
            $display("ERROR retire_wdata at pc %h got %h expected %h", exp_pc,
                     retire_wdata, exp_wdata);
          end
        end
      end
    end
  end

  task automatic load_program();
    int i;
    for (i = 0; i < 64; i++) begin
      rom[i] = 32'h0;
    end
    // alu, register and immediate forms
    rom[0]  = i_type('h13, 0, 1, 0, 5);
    rom[1]  = i_type('h13, 0, 2, 0, -3);
    rom[2]  = r_type(0, 0, 3, 1, 2);
    rom[3]  = r_type(32, 0, 4, 2, 1);
    rom[4]  = r_type(0, 2, 5, 2, 1);
    rom[5]  = r_type(0, 3, 6, 2, 1);
    rom[6]  = i_type('h13, 2, 7, 2, -1);
    rom[7]  = i_type('h13, 7, 8, 2, 'hf0);
    rom[8]  = i_type('h13, 6, 9, 1, -256);
    rom[9]  = i_type('h13, 4, 10, 2, 'h55);
    rom[10] = r_type(0, 7, 11, 2, 9);
    rom[11] = r_type(0, 6, 12, 1, 4);
    rom[12] = r_type(0, 4, 13, 2, 4);
    // shifts by 40 need all six shamt bits
    rom[13] = i_type('h13, 0, 14, 0, 40);
    rom[14] = r_type(0, 1, 15, 2, 14);
    rom[15] = r_type(0, 5, 16, 2, 14);
    rom[16] = u_type('h37, 17, 'h80000);
    rom[17] = u_type('h17, 18, 'h12345);
    // x0 write dropped, then read back
    rom[18] = i_type('h13, 0, 0, 1, 7);
    rom[19] = r_type(0, 0, 19, 0, 1);
    // stores then loads, plus untouched words
    rom[20] = i_type('h13, 0, 20, 0, 256);
    rom[21] = s_type(4, 20, 8);
    rom[22] = s_type(13, 20, 16);
    rom[23] = i_type('h03, 3, 21, 20, 8);
    rom[24] = i_type('h03, 3, 22, 20, 16);
    rom[25] = i_type('h03, 3, 23, 0, 40);
    // branches, each skipped slot would write x24
    rom[26] = b_type(0, 1, 2, 8);
    rom[27] = b_type(1, 1, 2, 8);
    rom[28] = i_type('h13, 0, 24, 0, 99);
    rom[29] = b_type(4, 2, 1, 8);
    rom[30] = i_type('h13, 0, 24, 0, 98);
    rom[31] = b_type(5, 2, 1, 8);
    rom[32] = j_type(25, 8);
    rom[33] = i_type('h13, 0, 24, 0, 97);
    // odd jalr target, lands on 148
    rom[34] = i_type('h13, 0, 26, 0, 149);
    rom[35] = i_type('h67, 0, 27, 26, 0);
    rom[36] = i_type('h13, 0, 24, 0, 96);
    rom[37] = i_type('h03, 3, 28, 20, 0);
    rom[38] = 32'hffff_ffff;
    rom[39] = EBREAK;
  endtask

  // reset, run until halt, then check the stop flags
  task automatic run_program(input logic expect_ill);
    int i;
    int cycles;
    for (i = 0; i < 64; i++) begin
      init_mem[i] = {$urandom(), $urandom()};
    end
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    while (!halt && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
    // a few idle cycles to catch stray retires
    repeat (4) @(posedge clk);
    assert (ref_halted) else begin
      end_errors++;
      $display("core halted before the reference reached its stop instruction");
    end
    assert (halt == 1'b1) else begin
      end_errors++;
      $display("ERROR halt got %h expected %h", halt, 1'b1);
    end
    assert (illegal == expect_ill) else begin
      end_errors++;
      $display("ERROR illegal got %h expected %h", illegal, expect_ill);
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    seed_ret = $urandom(32'h2826_e86f);
    load_program();
    // illegal word stops the first run
    run_program(1'b1);
    rom[38] = EBREAK;
    run_program(1'b0);
    $display("retires checked %0d, trace errors %0d, status errors %0d", checks,
             cmp_errors, end_errors);
    if (cmp_errors == 0 && end_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/rv_core_props.sv */
// bound concurrent checks on the wishbone master and retire trace
`default_nettype none
`include "rv_cfg.svh"

module rv_core_props (
  input wire logic                         clk,
  input wire logic                         rst_n,
  input wire logic                         wb_cyc,
  input wire logic                         wb_stb,
  input wire logic                         wb_ack,
  input wire logic                         wb_we,
  input wire logic [`RV_XLEN-1:0]          wb_adr,
  input wire logic [`RV_XLEN-1:0]          wb_wdata,
  input wire logic                         halt,
  input wire logic                         retire_valid,
  input wire logic                         retire_wen,
  input wire logic [$clog2(`RV_NREGS)-1:0] retire_rd
);

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb |-> wb_cyc)
    else $error("wishbone strobe high without cycle");

  // request held steady through wait states
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_wdata) && $stable(wb_we)))
    else $error("wishbone request changed before ack");

  a_no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halt |-> !retire_valid)
    else $error("retire reported while halted");

  // x0 is never a write target in the trace
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> !(retire_wen && retire_rd == '0))
    else $error("retire reports a write to x0");

endmodule

`default_nettype wire

/* hw/rv_core_top.sv */
// single-cycle rv64i core top level
`default_nettype none
`include "rv_cfg.svh"

module rv_core_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // instruction fetch, combinational
  output logic [`RV_XLEN-1:0]          imem_addr,
  input  logic [31:0]                  imem_data,
  // wishbone classic master
  output logic [`RV_XLEN-1:0]          wb_adr,
  output logic [`RV_XLEN-1:0]          wb_wdata,
  output logic                         wb_we,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  input  logic [`RV_XLEN-1:0]          wb_rdata,
  input  logic                         wb_ack,
  // status
  output logic                         halt,
  output logic                         illegal,
  // retire trace
  output logic                         retire_valid,
  output logic [`RV_XLEN-1:0]          retire_pc,
  output logic [$clog2(`RV_NREGS)-1:0] retire_rd,
  output logic [`RV_XLEN-1:0]          retire_wdata,
  output logic                         retire_wen
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rdata1;
  logic [`RV_XLEN-1:0] rdata2;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] next_pc;
  logic                reg_wen;
  logic [`RV_XLEN-1:0] reg_wdata;

  rv_dec_if dec_bus ();

  assign imem_addr = pc;

  rv_decode u_decode (
    .instr (imem_data),
    .dec   (dec_bus)
  );

  // read indices come straight off the decoded bundle
  rv_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (dec_bus.rs1),
    .rs2    (dec_bus.rs2),
    .rd     (dec_bus.rd),
    .wen    (reg_wen),
    .wdata  (reg_wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  rv_execute u_execute (
    .dec        (dec_bus),
    .pc         (pc),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .alu_result (alu_result),
    .next_pc    (next_pc)
  );

  rv_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec          (dec_bus),
    .alu_result   (alu_result),
    .next_pc      (next_pc),
    .rdata2       (rdata2),
    .wb_rdata     (wb_rdata),
    .wb_ack       (wb_ack),
    .pc           (pc),
    .wb_adr       (wb_adr),
    .wb_wdata     (wb_wdata),
    .wb_we        (wb_we),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .reg_wen      (reg_wen),
    .reg_wdata    (reg_wdata),
    .halt         (halt),
    .illegal      (illegal),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata),
    .retire_wen   (retire_wen)
  );

endmodule

`default_nettype wire

/* hw/rv_result.sv */
// pc register, wishbone master, write-back select and retire trace
`default_nettype none
`include "rv_cfg.svh"

module rv_result import rv_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  rv_dec_if.res                        dec,
  input  logic [`RV_XLEN-1:0]          alu_result,
  input  logic [`RV_XLEN-1:0]          next_pc,
  input  logic [`RV_XLEN-1:0]          rdata2,
  input  logic [`RV_XLEN-1:0]          wb_rdata,
  input  logic                         wb_ack,
  output logic [`RV_XLEN-1:0]          pc,
  output logic [`RV_XLEN-1:0]          wb_adr,
  output logic [`RV_XLEN-1:0]          wb_wdata,
  output logic                         wb_we,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         reg_wen,
  output logic [`RV_XLEN-1:0]          reg_wdata,
  output logic                         halt,
  output logic                         illegal,
  output logic                         retire_valid,
  output logic [`RV_XLEN-1:0]          retire_pc,
  output logic [$clog2(`RV_NREGS)-1:0] retire_rd,
  output logic [`RV_XLEN-1:0]          retire_wdata,
  output logic                         retire_wen
);

  logic mem_op;
  logic retire;
  logic wen_eff;

  assign mem_op = dec.is_load | dec.is_store;

  // bus request straight from decode, held until ack
  assign wb_cyc   = mem_op && !halt;
  assign wb_stb   = wb_cyc;
  assign wb_we    = dec.is_store;
  assign wb_adr   = alu_result;
  assign wb_wdata = rdata2;

  // memory ops finish on ack, the rest in one cycle
  assign retire = !halt && (!mem_op || wb_ack);

  // x0 writes are dropped here so the trace never shows them
  assign wen_eff = dec.reg_wen && (dec.rd != '0);

  always_comb begin
    case (dec.wb_src)
      WB_MEM:  reg_wdata = wb_rdata;
      WB_LINK: reg_wdata = pc + `RV_XLEN'd4;
      default: reg_wdata = alu_result;
    endcase
  end

  assign reg_wen = retire && wen_eff;

  // trace of the instruction at the current pc
  assign retire_valid = retire;
  assign retire_pc    = pc;
  assign retire_rd    = dec.rd;
  assign retire_wen   = wen_eff;
  assign retire_wdata = wen_eff ? reg_wdata : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= `RV_PC_RESET;
      halt    <= 1'b0;
      illegal <= 1'b0;
    end else if (retire) begin
      if (dec.ebreak || dec.illegal) begin
        // pc frozen, fetch effectively stops
        halt    <= 1'b1;
        illegal <= dec.illegal;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
// operand select, alu, branch decision and next pc
`default_nettype none
`include "rv_cfg.svh"

module rv_execute import rv_pkg::*; (
  rv_dec_if.exe               dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rdata1,
  input  logic [`RV_XLEN-1:0] rdata2,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [5:0]          shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                taken;

  // auipc and jal add to the pc
  assign op_a  = (dec.op_a == OPA_PC) ? pc : rdata1;
  assign op_b  = dec.use_imm ? dec.imm : rdata2;
  // 64-bit shifts use six bits
  assign shamt = op_b[5:0];

  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_PASS_B: alu_result = op_b;
      // branch compares, result is 0 or 1
      ALU_EQ:     alu_result = {{(`RV_XLEN-1){1'b0}}, eq};
      ALU_NE:     alu_result = {{(`RV_XLEN-1){1'b0}}, !eq};
      ALU_LT:     alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_GE:     alu_result = {{(`RV_XLEN-1){1'b0}}, !lt_s};
      default:    alu_result = '0;
    endcase
  end

  assign taken = dec.is_branch && alu_result[0];

  // jumps drop bit 0 of the alu sum
  always_comb begin
    if (dec.is_jump) begin
      next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + `RV_XLEN'd4;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// integer register file, two read ports and one write port
`default_nettype none
`include "rv_cfg.svh"

module rv_regfile (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [$clog2(`RV_NREGS)-1:0] rs1,
  input  logic [$clog2(`RV_NREGS)-1:0] rs2,
  input  logic [$clog2(`RV_NREGS)-1:0] rd,
  input  logic                         wen,
  input  logic [`RV_XLEN-1:0]          wdata,
  output logic [`RV_XLEN-1:0]          rdata1,
  output logic [`RV_XLEN-1:0]          rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // whole file clears on reset, x0 never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, same cycle as decode
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
// rv64i subset instruction decoder
`default_nettype none
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
  input  logic [31:0] instr,
  rv_dec_if.dec       dec
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // register fields sit at fixed positions for every format
  assign dec.rd  = instr[11:7];
  assign dec.rs1 = instr[19:15];
  assign dec.rs2 = instr[24:20];

  // immediates, all sign extended from bit 31
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  always_comb begin
    // defaults describe a no-op
    dec.imm       = imm_i;
    dec.use_imm   = 1'b0;
    dec.op_a      = OPA_REG;
    dec.alu_op    = ALU_ADD;
    dec.is_branch = 1'b0;
    dec.is_jump   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.reg_wen   = 1'b0;
    dec.wb_src    = WB_ALU;
    dec.illegal   = 1'b0;
    dec.ebreak    = 1'b0;
    case (instr[6:0])
      OP_LUI: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = ALU_PASS_B;
        dec.reg_wen = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.op_a    = OPA_PC;
        dec.reg_wen = 1'b1;
      end
      OP_JAL: begin
        // target is pc + imm through the alu
        dec.imm     = imm_j;
        dec.use_imm = 1'b1;
        dec.op_a    = OPA_PC;
        dec.is_jump = 1'b1;
        dec.reg_wen = 1'b1;
        dec.wb_src  = WB_LINK;
      end
      OP_JALR: begin
        dec.use_imm = 1'b1;
        dec.is_jump = 1'b1;
        dec.reg_wen = 1'b1;
        dec.wb_src  = WB_LINK;
        dec.illegal = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        // alu compares rs1 with rs2, imm kept for the target
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_EQ;
          3'b001:  dec.alu_op = ALU_NE;
          3'b100:  dec.alu_op = ALU_LT;
          3'b101:  dec.alu_op = ALU_GE;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        // ld only
        dec.use_imm = 1'b1;
        dec.is_load = 1'b1;
        dec.reg_wen = 1'b1;
        dec.wb_src  = WB_MEM;
        dec.illegal = (funct3 != 3'b011);
      end
      OP_STORE: begin
        // sd only
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
        dec.illegal  = (funct3 != 3'b011);
      end
      OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_ADD;
          3'b010:  dec.alu_op = ALU_SLT;
          3'b100:  dec.alu_op = ALU_XOR;
          3'b110:  dec.alu_op = ALU_OR;
          3'b111:  dec.alu_op = ALU_AND;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_REG: begin
        dec.reg_wen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_111: dec.alu_op = ALU_AND;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_010: dec.alu_op = ALU_SLT;
          10'b0000000_011: dec.alu_op = ALU_SLTU;
          10'b0000000_001: dec.alu_op = ALU_SLL;
          10'b0000000_101: dec.alu_op = ALU_SRL;
          default:         dec.illegal = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        // only the exact ebreak word is accepted
        dec.ebreak  = (instr == 32'h0010_0073);
        dec.illegal = (instr != 32'h0010_0073);
      end
      default: dec.illegal = 1'b1;
    endcase
    // nothing may write or move data on a bad encoding
    if (dec.illegal) begin
      dec.reg_wen   = 1'b0;
      dec.is_load   = 1'b0;
      dec.is_store  = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_jump   = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* common/rv_dec_if.sv */
// decoded instruction bundle between decode, execute and result
`default_nettype none
`include "rv_cfg.svh"

interface rv_dec_if import rv_pkg::*; ();

  // register indices
  logic [$clog2(`RV_NREGS)-1:0] rd;
  logic [$clog2(`RV_NREGS)-1:0] rs1;
  logic [$clog2(`RV_NREGS)-1:0] rs2;
  // sign-extended immediate
  logic [`RV_XLEN-1:0] imm;
  logic                use_imm;
  op_a_src_t           op_a;
  alu_op_t             alu_op;
  // flow and memory flags
  logic                is_branch;
  logic                is_jump;
  logic                is_load;
  logic                is_store;
  // write-back control
  logic                reg_wen;
  wb_src_t             wb_src;
  // stop causes
  logic                illegal;
  logic                ebreak;

  modport dec (
    output rd, rs1, rs2, imm, use_imm, op_a, alu_op, is_branch, is_jump,
           is_load, is_store, reg_wen, wb_src, illegal, ebreak
  );

  modport exe (
    input imm, use_imm, op_a, alu_op, is_branch, is_jump
  );

  modport res (
    input rd, is_load, is_store, reg_wen, wb_src, illegal, ebreak
  );

endinterface

`default_nettype wire

/* common/rv_pkg.sv */
// opcode, alu operation, write-back source and operand a types
`default_nettype none

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  // last four give 1 or 0 for branch decisions
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_PASS_B,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE
  } alu_op_t;

  // link means pc plus 4
  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_LINK
  } wb_src_t;

  typedef enum logic {
    OPA_REG, OPA_PC
  } op_a_src_t;

endpackage

`default_nettype wire

/* common/rv_cfg.svh */
// core width, reset pc and register count macros
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 64

// pc after reset
`define RV_PC_RESET 64'h0

// integer register count, x0 included
`define RV_NREGS 32

`endif
